/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f hc_loopback.f \
		--top-module tb_hc_loopback -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hc_loopback.f */
verilog/hc_pkg.sv
verilog/loopback_fifo.sv
verilog/stream_reader.sv
verilog/stream_writer.sv
verilog/loopback.sv
verilog/hc_loopback_top.sv
test/tb_hc_loopback.sv

/* test/tb_hc_loopback.sv */
// Loopback subsystem testbench

module tb_hc_loopback;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SIZE_PLAIN  = 64;
  localparam int SIZE_STALL  = 256;
  localparam int SIZE_MIN    = 16;
  localparam int SIZE_RELOAD = 40;
  localparam int TIMEOUT_CYCLES =
    8 * (SIZE_PLAIN + SIZE_STALL + SIZE_MIN + SIZE_RELOAD) + 500;

  logic                         clk;
  logic                         reset;
  logic                         start;
  logic [hc_pkg::SIZE_BITS-1:0] src_size;
  logic                         stall = 1'b0;
  logic                         load_en;
  logic [hc_pkg::ADDR_BITS-1:0] load_addr;
  hc_pkg::t_word                load_data;
  logic [hc_pkg::ADDR_BITS-1:0] dump_addr = '0;
  logic                         finish;
  hc_pkg::t_word                dump_data;

  hc_pkg::t_word src_model [hc_pkg::BUF_DEPTH];    // words as loaded into the source
  logic [15:0]   lfsr_state;
  logic [31:0]   stall_bits;
  logic          stall_random;
  int            dump_len;
  int            errors;
  int            checks;
  int            cycles = 0;
  event          dump_start;
  event          dump_done;

  hc_loopback_top u_hc_loopback_top (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .src_size  (src_size),
    .stall     (stall),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .dump_addr (dump_addr),
    .finish    (finish),
    .dump_data (dump_data)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // random bits and the reference model
  //////////////////////////////////////////////////

  // taps 16 14 13 11 give a maximal length sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // a loopback copies, so the destination must hold what was loaded
  function automatic hc_pkg::t_word expected_word(input int addr);
    return src_model[addr];
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic reset_dut();
    @(posedge clk);
    reset   <= 1'b1;
    start   <= 1'b0;
    load_en <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (finish === 1'b0) else begin
        errors++;
        $display("ERR finish expected=%h actual=%h after reset", 1'b0, finish);
      end
    end
  endtask

  task automatic load_source(input int size);
    logic [31:0] bits;
    for (int a = 0; a < size; a++) begin
      take_bits(32, bits);
      src_model[a] = bits;
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= (hc_pkg::ADDR_BITS)'(a);
      load_data <= bits;
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic run_copy(input int size, input logic random_stall);
    reset_dut();
    load_source(size);
    @(posedge clk);
    src_size  <= (hc_pkg::SIZE_BITS)'(size);
    start     <= 1'b1;
    dump_addr <= (hc_pkg::ADDR_BITS)'(size - 1);    // the last word lands only at the very end
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    stall_random = random_stall;
    while (finish !== 1'b1) @(negedge clk);    // the cycle counter catches a hang
    checks++;
    assert (dump_data === expected_word(size - 1)) else begin
      errors++;
      $display("ERR dump_data addr=%h expected=%h actual=%h as finish rose",
               dump_addr, expected_word(size - 1), dump_data);
    end
    stall_random = 1'b0;
    dump_len = size;
    -> dump_start;
    @(dump_done);
  endtask

  //////////////////////////////////////////////////
  // stall pattern, dump compare and timeout
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (stall_random) begin
      take_bits(1, stall_bits);
      stall <= stall_bits[0];    // about half the cycles stall
    end else begin
      stall <= 1'b0;
    end
  end

  always begin
    @(dump_start);
    for (int a = 0; a < dump_len; a++) begin
      @(posedge clk);
      dump_addr <= (hc_pkg::ADDR_BITS)'(a);
      @(negedge clk);
      checks++;
      assert (dump_data === expected_word(a)) else begin
        errors++;
        $display("ERR dump_data addr=%h expected=%h actual=%h",
                 dump_addr, expected_word(a), dump_data);
      end
      // finish has to hold for as long as no reset comes
      assert (finish === 1'b1) else begin
        errors++;
        $display("ERR finish addr=%h expected=%h actual=%h", dump_addr, 1'b1, finish);
      end
    end
    -> dump_done;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: finish never arrived within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    src_size     = '0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    lfsr_state   = 16'd69;
    stall_random = 1'b0;
    dump_len     = 0;
    errors       = 0;
    checks       = 0;

    run_copy(SIZE_PLAIN, 1'b0);
    run_copy(SIZE_STALL, 1'b1);
    run_copy(SIZE_MIN, 1'b0);     // priming burst alone covers the copy
    run_copy(SIZE_RELOAD, 1'b0);  // fresh data after another reset

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_hc_loopback

/* verilog/hc_loopback_top.sv */
// Loopback subsystem top

module hc_loopback_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic [hc_pkg::SIZE_BITS-1:0] src_size,
  input  logic                         stall,
  input  logic                         load_en,
  input  logic [hc_pkg::ADDR_BITS-1:0] load_addr,
  input  hc_pkg::t_word                load_data,
  input  logic [hc_pkg::ADDR_BITS-1:0] dump_addr,
  output logic                         finish,
  output hc_pkg::t_word                dump_data
);

  logic                         rd_req;
  logic [hc_pkg::SIZE_BITS-1:0] rd_len;
  logic                         rd_valid;
  hc_pkg::t_word                rd_data;
  logic                         fifo_enq_en;
  hc_pkg::t_word                fifo_enq_data;
  logic                         fifo_deq_en;
  hc_pkg::t_word                fifo_deq_data;
  logic                         fifo_full;
  logic                         fifo_empty;
  logic                         wr_en;
  hc_pkg::t_word                wr_data;
  logic                         wr_stall;

  loopback u_loopback (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .src_size      (src_size),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty),
    .fifo_deq_data (fifo_deq_data),
    .wr_stall      (wr_stall),
    .finish        (finish),
    .rd_req        (rd_req),
    .rd_len        (rd_len),
    .fifo_enq_en   (fifo_enq_en),
    .fifo_enq_data (fifo_enq_data),
    .fifo_deq_en   (fifo_deq_en),
    .wr_en         (wr_en),
    .wr_data       (wr_data)
  );

  loopback_fifo u_loopback_fifo (
    .clk      (clk),
    .reset    (reset),
    .enq_en   (fifo_enq_en),
    .enq_data (fifo_enq_data),
    .deq_en   (fifo_deq_en),
    .deq_data (fifo_deq_data),
    .full     (fifo_full),
    .empty    (fifo_empty)
  );

  stream_reader u_stream_reader (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_req    (rd_req),
    .rd_len    (rd_len),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  stream_writer u_stream_writer (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .dump_addr (dump_addr),
    .wr_stall  (wr_stall),
    .dump_data (dump_data)
  );

endmodule : hc_loopback_top

/* verilog/hc_pkg.sv */
// Loopback shared definitions

package hc_pkg;

  //////////////////////////////////////////////////
  // data and buffer sizes
  //////////////////////////////////////////////////

  localparam int WORD_BITS = 32;
  localparam int BUF_DEPTH = 256;
  localparam int ADDR_BITS = 8;
  localparam int SIZE_BITS = 9;    // holds a size of up to BUF_DEPTH

  typedef logic [WORD_BITS-1:0] t_word;

  //////////////////////////////////////////////////
  // FIFO sizing and refill policy
  //////////////////////////////////////////////////

  localparam int FIFO_DEPTH       = 16;
  localparam int FIFO_PTR_BITS    = $clog2(FIFO_DEPTH);
  localparam int PRIME_BURST      = 16;   // one full FIFO worth
  localparam int REFILL_BURST     = 8;
  localparam int REFILL_THRESHOLD = 8;

  typedef enum logic [1:0] {
    ST_START,
    ST_READ,
    ST_FINISH
  } t_loopback_state;

endpackage : hc_pkg

/* verilog/loopback.sv */
// Loopback controller

module loopback (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic [hc_pkg::SIZE_BITS-1:0] src_size,
  input  logic                         rd_valid,
  input  hc_pkg::t_word                rd_data,
  input  logic                         fifo_full,
  input  logic                         fifo_empty,
  input  hc_pkg::t_word                fifo_deq_data,
  input  logic                         wr_stall,
  output logic                         finish,
  output logic                         rd_req,
  output logic [hc_pkg::SIZE_BITS-1:0] rd_len,
  output logic                         fifo_enq_en,
  output hc_pkg::t_word                fifo_enq_data,
  output logic                         fifo_deq_en,
  output logic                         wr_en,
  output hc_pkg::t_word                wr_data
);

  hc_pkg::t_loopback_state state;

  logic [hc_pkg::SIZE_BITS-1:0] count_read;
  logic [hc_pkg::SIZE_BITS-1:0] count_write;
  logic [hc_pkg::SIZE_BITS-1:0] outstanding;

  // words requested but not yet written, wherever they are in the pipe
  assign outstanding = count_read - count_write;

  //////////////////////////////////////////////////
  // read request FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= hc_pkg::ST_START;
      count_read <= '0;
      rd_req     <= 1'b0;
      rd_len     <= '0;
    end else begin
      rd_req <= 1'b0;
      case (state)
        hc_pkg::ST_START: begin
          if (start) begin
            rd_req     <= 1'b1;
            rd_len     <= (hc_pkg::SIZE_BITS)'(hc_pkg::PRIME_BURST);
            count_read <= count_read + (hc_pkg::SIZE_BITS)'(hc_pkg::PRIME_BURST);
            state      <= hc_pkg::ST_READ;
          end
        end
        hc_pkg::ST_READ: begin
          if (count_read == src_size) begin
            state <= hc_pkg::ST_FINISH;    // all words requested
          end else if (outstanding < (hc_pkg::SIZE_BITS)'(hc_pkg::REFILL_THRESHOLD)) begin
            rd_req     <= 1'b1;
            rd_len     <= (hc_pkg::SIZE_BITS)'(hc_pkg::REFILL_BURST);
            count_read <= count_read + (hc_pkg::SIZE_BITS)'(hc_pkg::REFILL_BURST);
          end
        end
        default: state <= hc_pkg::ST_FINISH;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // response into the FIFO, head out to the writer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fifo_enq_en <= 1'b0;
      wr_en       <= 1'b0;
      count_write <= '0;
    end else begin
      fifo_enq_en <= rd_valid;
      wr_en       <= fifo_deq_en;
      if (wr_en) begin
        count_write <= count_write + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    fifo_enq_data <= rd_data;
    wr_data       <= fifo_deq_data;
  end

  assign fifo_deq_en = !fifo_empty && !wr_stall;
  assign finish      = (state == hc_pkg::ST_FINISH) && (count_write == src_size);

  a_read_bound : assert property (@(posedge clk) disable iff (reset)
    count_read <= src_size)
    else $error("loopback: requested more words than src_size");

  // a full FIFO means every outstanding word is sitting in it
  a_full_matches_count : assert property (@(posedge clk) disable iff (reset)
    fifo_full |-> (outstanding == (hc_pkg::SIZE_BITS)'(hc_pkg::FIFO_DEPTH)))
    else $error("loopback: FIFO full does not match the outstanding count");

endmodule : loopback

/* verilog/loopback_fifo.sv */
// Loopback word FIFO

module loopback_fifo (
  input  logic         clk,
  input  logic         reset,
  input  logic         enq_en,
  input  hc_pkg::t_word enq_data,
  input  logic         deq_en,
  output hc_pkg::t_word deq_data,
  output logic         full,
  output logic         empty
);

  hc_pkg::t_word mem [hc_pkg::FIFO_DEPTH];

  logic [hc_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
  logic [hc_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
  logic [hc_pkg::FIFO_PTR_BITS:0]   count;

  // head word is visible without a read cycle
  assign deq_data = mem[rd_ptr];
  assign full     = (count == (hc_pkg::FIFO_PTR_BITS + 1)'(hc_pkg::FIFO_DEPTH));
  assign empty    = (count == '0);

  always_ff @(posedge clk) begin
    if (enq_en) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_en) begin
        wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two so pointers wrap freely
      end
      if (deq_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({enq_en, deq_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    enq_en |-> !full)
    else $error("loopback_fifo: enqueue while full");

  a_no_underflow : assert property (@(posedge clk) disable iff (reset)
    deq_en |-> !empty)
    else $error("loopback_fifo: dequeue while empty");

endmodule : loopback_fifo

/* verilog/stream_reader.sv */
// Source buffer burst reader

module stream_reader (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         load_en,
  input  logic [hc_pkg::ADDR_BITS-1:0] load_addr,
  input  hc_pkg::t_word                load_data,
  input  logic                         rd_req,
  input  logic [hc_pkg::SIZE_BITS-1:0] rd_len,
  output logic                         rd_valid,
  output hc_pkg::t_word                rd_data
);

  hc_pkg::t_word mem [hc_pkg::BUF_DEPTH];

  logic [hc_pkg::SIZE_BITS-1:0] remaining;
  logic [hc_pkg::SIZE_BITS-1:0] avail;
  logic [hc_pkg::ADDR_BITS-1:0] rd_addr;

  //////////////////////////////////////////////////
  // source memory, filled through the load port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  //////////////////////////////////////////////////
  // burst engine
  //////////////////////////////////////////////////

  // a request in this cycle counts at once, so the first word leaves on the next edge
  assign avail = remaining + (rd_req ? rd_len : '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      remaining <= '0;
      rd_addr   <= '0;
      rd_valid  <= 1'b0;
    end else begin
      if (avail != '0) begin
        remaining <= avail - 1'b1;
        rd_addr   <= rd_addr + 1'b1;    // source is read strictly in order
        rd_valid  <= 1'b1;
      end else begin
        remaining <= '0;
        rd_valid  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (avail != '0) begin
      rd_data <= mem[rd_addr];
    end
  end

  a_no_req_during_load : assert property (@(posedge clk) disable iff (reset)
    rd_req |-> !load_en)
    else $error("stream_reader: read request while the source is being loaded");

endmodule : stream_reader

/* verilog/stream_writer.sv */
// Destination buffer stream writer

module stream_writer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stall,
  input  logic                         wr_en,
  input  hc_pkg::t_word                wr_data,
  input  logic [hc_pkg::ADDR_BITS-1:0] dump_addr,
  output logic                         wr_stall,
  output hc_pkg::t_word                dump_data
);

  hc_pkg::t_word mem [hc_pkg::BUF_DEPTH];

  // one bit wider than an address so a full buffer is told apart from an empty one
  logic [hc_pkg::SIZE_BITS-1:0] wr_ptr;

  //////////////////////////////////////////////////
  // sequential write side
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[hc_pkg::ADDR_BITS-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // back-pressure comes straight from outside
  assign wr_stall = stall;

  //////////////////////////////////////////////////
  // dump port
  //////////////////////////////////////////////////

  assign dump_data = mem[dump_addr];    // combinational, for readback after finish

  a_no_wrap : assert property (@(posedge clk) disable iff (reset)
    wr_en |-> (wr_ptr < (hc_pkg::SIZE_BITS)'(hc_pkg::BUF_DEPTH)))
    else $error("stream_writer: write pointer ran past the buffer end");

endmodule : stream_writer
